/* src/hps_input_pkg.sv */
`default_nettype none

package hps_input_pkg;

	// highest player count the command set can address
	localparam int MAX_PLAYERS = 6;

	////////////////////////////////////////
	// host command codes
	////////////////////////////////////////
	localparam logic [15:0] CMD_JOY_0      = 16'h0002;
	localparam logic [15:0] CMD_JOY_1      = 16'h0003;
	localparam logic [15:0] CMD_JOY_2      = 16'h0010;
	localparam logic [15:0] CMD_JOY_3      = 16'h0011;
	localparam logic [15:0] CMD_JOY_4      = 16'h0012;
	localparam logic [15:0] CMD_JOY_5      = 16'h0013;
	localparam logic [15:0] CMD_KBD        = 16'h0005;
	localparam logic [15:0] CMD_ANALOG_L   = 16'h001A;
	localparam logic [15:0] CMD_STATUS     = 16'h001E;
	localparam logic [15:0] CMD_STATUS_SET = 16'h0029;
	localparam logic [15:0] CMD_ANALOG_R   = 16'h003D;

	// top nibble of the first status-set reply
	localparam logic [3:0] STATUS_SET_TAG = 4'hA;

	////////////////////////////////////////
	// keyboard sequences with fixed codes
	////////////////////////////////////////
	localparam logic [31:0] KEY_PRNSCR_DN      = 32'hE012_E07C;
	localparam logic [9:0]  KEY_PRNSCR_DN_CODE = 10'h37C;
	localparam logic [31:0] KEY_PRNSCR_UP      = 32'h7CE0_F012;
	localparam logic [9:0]  KEY_PRNSCR_UP_CODE = 10'h17C;
	localparam logic [31:0] KEY_PAUSE_DN       = 32'hF014_F077;
	localparam logic [9:0]  KEY_PAUSE_DN_CODE  = 10'h377;

	typedef enum logic [3:0] {
		WR_NONE,
		WR_BUTTONS_LO,
		WR_BUTTONS_HI,
		WR_ANALOG_L,
		WR_ANALOG_R,
		WR_PADDLE,
		WR_SPINNER,
		WR_STATUS_WORD,
		WR_KBD_BYTE,
		WR_KBD_CLEAR,
		WR_KBD_COMMIT
	} wr_kind_t;

	// one host data word, stick pair or paddle/spinner value
	typedef union packed {
		struct packed {
			logic signed [7:0] y;
			logic signed [7:0] x;
		} analog;
		struct packed {
			logic [7:0] unused;
			logic [7:0] value;
		} pad;
	} host_word_u;

	typedef struct packed {
		logic       valid;
		wr_kind_t   kind;
		logic [3:0] target;
		host_word_u data;
	} host_wr_t;

	typedef struct packed {
		logic [31:0] buttons;
		logic [15:0] analog_l;
		logic [15:0] analog_r;
		logic [7:0]  paddle;
		logic [8:0]  spinner;
	} player_t;

endpackage

`default_nettype wire

/* src/hps_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_decoder #(
	parameter int NUM_PLAYERS = hps_input_pkg::MAX_PLAYERS
) (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     io_enable,
	input  wire                     io_strobe,
	input  wire [15:0]              io_din,
	output logic [15:0]             io_dout,
	output hps_input_pkg::host_wr_t wr,
	input  wire [15:0]              status_rsp,
	output logic [2:0]              status_rsp_idx
);
	import hps_input_pkg::*;

	logic [15:0] cmd;
	logic [2:0]  word_cnt;
	logic [3:0]  stick_idx;
	logic [3:0]  pdsp_idx;
	logic        kbd_skip;
	logic [3:0]  joy_idx;
	logic [15:0] reply;
	host_wr_t    ev;

	// player index of a button command, 15 when not one
	always_comb begin
		case (cmd)
			CMD_JOY_0: joy_idx = 4'd0;
			CMD_JOY_1: joy_idx = 4'd1;
			CMD_JOY_2: joy_idx = 4'd2;
			CMD_JOY_3: joy_idx = 4'd3;
			CMD_JOY_4: joy_idx = 4'd4;
			CMD_JOY_5: joy_idx = 4'd5;
			default:   joy_idx = 4'hF;
		endcase
	end

	////////////////////////////////////////
	// write event for the current word
	////////////////////////////////////////
	always_comb begin
		ev      = '0;
		ev.kind = WR_NONE;
		ev.data = io_din;
		if (!io_enable) begin
			// frame closed, hand the keyboard bytes over
			if (cmd == CMD_KBD && !kbd_skip) begin
				ev.valid = 1'b1;
				ev.kind  = WR_KBD_COMMIT;
			end
		end else if (io_strobe) begin
			if (word_cnt == 3'd0) begin
				if (io_din == CMD_KBD) begin
					ev.valid = 1'b1;
					ev.kind  = WR_KBD_CLEAR;
				end
			end else if (joy_idx < NUM_PLAYERS) begin
				ev.valid  = 1'b1;
				ev.target = joy_idx;
				if (word_cnt == 3'd1)
					ev.kind = WR_BUTTONS_LO;
				else
					ev.kind = WR_BUTTONS_HI;
			end else begin
				case (cmd)
					CMD_KBD: begin
						if (!(&io_din[15:8]) && !kbd_skip) begin
							ev.valid = 1'b1;
							ev.kind  = WR_KBD_BYTE;
						end
					end
					CMD_STATUS: begin
						if (word_cnt <= 3'd4) begin
							ev.valid  = 1'b1;
							ev.kind   = WR_STATUS_WORD;
							ev.target = 4'(word_cnt) - 4'd1;
						end
					end
					CMD_ANALOG_L: begin
						if (word_cnt == 3'd2) begin
							if (stick_idx < NUM_PLAYERS) begin
								ev.valid  = 1'b1;
								ev.kind   = WR_ANALOG_L;
								ev.target = stick_idx;
							end else if (stick_idx == 4'hF) begin
								// stick 15 selects paddle 0..n or spinner 8..8+n
								if (pdsp_idx < NUM_PLAYERS) begin
									ev.valid  = 1'b1;
									ev.kind   = WR_PADDLE;
									ev.target = pdsp_idx;
								end else if (pdsp_idx >= 4'd8 && pdsp_idx < 8 + NUM_PLAYERS) begin
									ev.valid  = 1'b1;
									ev.kind   = WR_SPINNER;
									ev.target = pdsp_idx - 4'd8;
								end
							end
						end
					end
					CMD_ANALOG_R: begin
						if (word_cnt == 3'd2 && stick_idx < NUM_PLAYERS) begin
							ev.valid  = 1'b1;
							ev.kind   = WR_ANALOG_R;
							ev.target = stick_idx;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// reply word, only status-set answers
	always_comb begin
		status_rsp_idx = (word_cnt <= 3'd4) ? word_cnt : 3'd0;
		reply          = '0;
		if (word_cnt == 3'd0) begin
			if (io_din == CMD_STATUS_SET)
				reply = status_rsp;
		end else if (cmd == CMD_STATUS_SET && word_cnt <= 3'd4) begin
			reply = status_rsp;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd       <= '0;
			word_cnt  <= '0;
			stick_idx <= '0;
			pdsp_idx  <= '0;
			kbd_skip  <= 1'b0;
			io_dout   <= '0;
			wr        <= '0;
		end else begin
			wr <= ev;
			if (!io_enable) begin
				cmd      <= '0;
				word_cnt <= '0;
				kbd_skip <= 1'b0;
				io_dout  <= '0;
			end else if (io_strobe) begin
				io_dout <= reply;
				if (word_cnt != 3'd7)
					word_cnt <= word_cnt + 3'd1;
				if (word_cnt == 3'd0) begin
					cmd <= io_din;
				end else begin
					if (word_cnt == 3'd1)
						{pdsp_idx, stick_idx} <= io_din[7:0];
					// all-ones high byte drops the rest of the frame
					if (cmd == CMD_KBD && (&io_din[15:8]))
						kbd_skip <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/player_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module player_slot #(
	parameter int unsigned SLOT_ID = 0
) (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire hps_input_pkg::host_wr_t wr,
	output hps_input_pkg::player_t  player
);
	import hps_input_pkg::*;

	logic hit;

	// event addressed to this player
	assign hit = wr.valid && (wr.target == 4'(SLOT_ID));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			player <= '0;
		end else if (hit) begin
			case (wr.kind)
				WR_BUTTONS_LO: begin
					player.buttons[15:0] <= wr.data;
				end
				WR_BUTTONS_HI: begin
					player.buttons[31:16] <= wr.data;
				end
				// y in the high byte, x in the low byte
				WR_ANALOG_L: begin
					player.analog_l <= {wr.data.analog.y, wr.data.analog.x};
				end
				WR_ANALOG_R: begin
					player.analog_r <= {wr.data.analog.y, wr.data.analog.x};
				end
				WR_PADDLE: begin
					player.paddle <= wr.data.pad.value;
				end
				WR_SPINNER: begin
					// top bit flips so the core sees every update
					player.spinner <= {~player.spinner[8], wr.data.pad.value};
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/ps2_key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire hps_input_pkg::host_wr_t wr,
	output logic [10:0]             ps2_key
);
	import hps_input_pkg::*;

	logic [31:0] key_raw;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	////////////////////////////////////////
	// decode the collected bytes
	////////////////////////////////////////
	always_comb begin
		// F0 in byte 1 marks a release
		pressed = (key_raw[15:8] != 8'hF0);
		if (pressed)
			extended = (key_raw[15:8] == 8'hE0);
		else
			extended = (key_raw[23:16] == 8'hE0);
		key_code = {pressed, extended, key_raw[7:0]};

		// long sequences collapse to one code
		case (key_raw)
			KEY_PRNSCR_DN: key_code = KEY_PRNSCR_DN_CODE;
			KEY_PRNSCR_UP: key_code = KEY_PRNSCR_UP_CODE;
			KEY_PAUSE_DN:  key_code = KEY_PAUSE_DN_CODE;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_raw <= '0;
			ps2_key <= '0;
		end else if (wr.valid) begin
			case (wr.kind)
				WR_KBD_CLEAR: begin
					key_raw <= '0;
				end
				WR_KBD_BYTE: begin
					key_raw <= {key_raw[23:0], wr.data[7:0]};
				end
				WR_KBD_COMMIT: begin
					// bit 10 toggles on every event
					ps2_key <= {~ps2_key[10], key_code};
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module status_regs (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire hps_input_pkg::host_wr_t wr,
	output logic [63:0]             status,
	input  wire [63:0]              status_in,
	input  wire                     status_set,
	input  wire [2:0]               status_rsp_idx,
	output logic [15:0]             status_rsp
);
	import hps_input_pkg::*;

	logic [63:0] status_req;
	logic        status_set_d;
	logic        set_pending;
	logic [3:0]  set_cnt;

	////////////////////////////////////////
	// host side status word
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else if (wr.valid && wr.kind == WR_STATUS_WORD) begin
			status[{wr.target[1:0], 4'b0000} +: 16] <= wr.data;
		end
	end

	////////////////////////////////////////
	// core requested status
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			set_pending  <= 1'b0;
			set_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			set_pending  <= status_set && !status_set_d;
			// word taken on the rising edge
			if (status_set && !status_set_d)
				status_req <= status_in;
			// counter follows one cycle behind
			if (set_pending)
				set_cnt <= set_cnt + 4'd1;
		end
	end

	// reply words for the status-set command
	always_comb begin
		case (status_rsp_idx)
			3'd0:    status_rsp = {STATUS_SET_TAG, 8'h00, set_cnt};
			3'd1:    status_rsp = status_req[15:0];
			3'd2:    status_rsp = status_req[31:16];
			3'd3:    status_rsp = status_req[47:32];
			3'd4:    status_rsp = status_req[63:48];
			default: status_rsp = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/hps_input_hub.sv */
`timescale 1ns/1ps
`default_nettype none

module hps_input_hub #(
	parameter int NUM_PLAYERS = hps_input_pkg::MAX_PLAYERS
) (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire                         io_enable,
	input  wire                         io_strobe,
	input  wire [15:0]                  io_din,
	output wire [15:0]                  io_dout,
	output wire hps_input_pkg::player_t players [NUM_PLAYERS],
	output wire [63:0]                  status,
	input  wire [63:0]                  status_in,
	input  wire                         status_set,
	output wire [10:0]                  ps2_key
);
	import hps_input_pkg::*;

	host_wr_t    wr;
	logic [15:0] status_rsp;
	logic [2:0]  status_rsp_idx;

	////////////////////////////////////////
	// host command framing
	////////////////////////////////////////
	hps_cmd_decoder #(
		.NUM_PLAYERS(NUM_PLAYERS)
	) i_cmd_decoder (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.io_enable      (io_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.io_dout        (io_dout),
		.wr             (wr),
		.status_rsp     (status_rsp),
		.status_rsp_idx (status_rsp_idx)
	);

	// one slot per player
	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
		player_slot #(
			.SLOT_ID(i)
		) i_player_slot (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.wr      (wr),
			.player  (players[i])
		);
	end

	ps2_key_decoder i_ps2_key_decoder (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr      (wr),
		.ps2_key (ps2_key)
	);

	status_regs i_status_regs (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.wr             (wr),
		.status         (status),
		.status_in      (status_in),
		.status_set     (status_set),
		.status_rsp_idx (status_rsp_idx),
		.status_rsp     (status_rsp)
	);

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS    = 10.0,
	parameter int  RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_sys = ~clk_sys;
	end

	// release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/hps_input_hub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hps_input_hub_tb;
	import hps_input_pkg::*;

	localparam int NUM_PLAYERS = 6;
	localparam int SETTLE      = 3;
	localparam int WAIT_LIMIT  = 20;

	logic        clk_sys;
	logic        rst_n;
	logic        io_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	wire  [15:0] io_dout;
	wire player_t players [NUM_PLAYERS];
	wire  [63:0] status;
	logic [63:0] status_in;
	logic        status_set;
	wire  [10:0] ps2_key;

	logic [31:0] rng_state;
	int          mismatches;
	int          timeouts;

	// reference model state
	logic [31:0] m_buttons [NUM_PLAYERS];
	logic [15:0] m_analog_l [NUM_PLAYERS];
	logic [15:0] m_analog_r [NUM_PLAYERS];
	logic [7:0]  m_paddle [NUM_PLAYERS];
	logic [8:0]  m_spinner [NUM_PLAYERS];
	logic [63:0] m_status;
	logic [63:0] m_status_req;
	logic [3:0]  m_set_cnt;
	logic [10:0] m_ps2_key;

	// data words of the next frame and the replies seen
	logic [15:0] words [$];
	logic [15:0] replies [$];

	tb_clock_gen i_clock_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	hps_input_hub #(
		.NUM_PLAYERS(NUM_PLAYERS)
	) i_dut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.io_dout    (io_dout),
		.players    (players),
		.status     (status),
		.status_in  (status_in),
		.status_set (status_set),
		.ps2_key    (ps2_key)
	);

	// lcg upper half only since the low bits repeat quickly
	function automatic logic [15:0] rand16();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	function automatic int rand_below(input int n);
		return int'(rand16()) % n;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		mismatches++;
		$display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic wait_reset_release();
		int cnt;
		cnt = 0;
		while (rst_n !== 1'b1 && cnt < WAIT_LIMIT) begin
			idle_cycles(1);
			cnt++;
		end
		if (rst_n !== 1'b1) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
	endtask

	task automatic wait_key_toggle(input logic old_toggle);
		int cnt;
		cnt = 0;
		while (ps2_key[10] === old_toggle && cnt < WAIT_LIMIT) begin
			idle_cycles(1);
			cnt++;
		end
		if (ps2_key[10] === old_toggle) begin
			timeouts++;
			$display("timeout: keyboard event never reached ps2_key");
		end
	endtask

	////////////////////////////////////////
	// host frame
	////////////////////////////////////////
	task automatic strobe_word(input logic [15:0] w);
		io_din    = w;
		io_strobe = 1'b1;
		idle_cycles(1);
		io_strobe = 1'b0;
		io_din    = rand16();
		replies.push_back(io_dout);
	endtask

	task automatic send_frame(input logic [15:0] cmd);
		replies.delete();
		io_enable = 1'b1;
		idle_cycles(rand_below(3));
		strobe_word(cmd);
		foreach (words[i]) begin
			idle_cycles(rand_below(3));
			strobe_word(words[i]);
		end
		idle_cycles(rand_below(3));
		io_enable = 1'b0;
		idle_cycles(1);
		if (io_dout !== 16'h0000)
			report_mismatch("io_dout", io_dout, 64'h0);
	endtask

	task automatic check_no_reply();
		foreach (replies[i])
			if (replies[i] !== 16'h0000)
				report_mismatch($sformatf("io_dout word %0d", i), replies[i], 64'h0);
	endtask

	task automatic check_state();
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			if (players[p].buttons !== m_buttons[p])
				report_mismatch($sformatf("players[%0d].buttons", p),
					players[p].buttons, m_buttons[p]);
			if (players[p].analog_l !== m_analog_l[p])
				report_mismatch($sformatf("players[%0d].analog_l", p),
					players[p].analog_l, m_analog_l[p]);
			if (players[p].analog_r !== m_analog_r[p])
				report_mismatch($sformatf("players[%0d].analog_r", p),
					players[p].analog_r, m_analog_r[p]);
			if (players[p].paddle !== m_paddle[p])
				report_mismatch($sformatf("players[%0d].paddle", p),
					players[p].paddle, m_paddle[p]);
			if (players[p].spinner !== m_spinner[p])
				report_mismatch($sformatf("players[%0d].spinner", p),
					players[p].spinner, m_spinner[p]);
		end
		if (status !== m_status)
			report_mismatch("status", status, m_status);
		if (ps2_key !== m_ps2_key)
			report_mismatch("ps2_key", ps2_key, m_ps2_key);
	endtask

	////////////////////////////////////////
	// scenarios
	////////////////////////////////////////
	task automatic button_frame();
		int          p;
		int          n;
		logic [15:0] cmd;
		p = rand_below(NUM_PLAYERS);
		n = 1 + rand_below(4);
		words.delete();
		for (int i = 0; i < n; i++)
			words.push_back(rand16());
		// first data word is the low half, the rest land in the high half
		m_buttons[p][15:0] = words[0];
		for (int i = 1; i < n; i++)
			m_buttons[p][31:16] = words[i];
		case (p)
			0:       cmd = CMD_JOY_0;
			1:       cmd = CMD_JOY_1;
			2:       cmd = CMD_JOY_2;
			3:       cmd = CMD_JOY_3;
			4:       cmd = CMD_JOY_4;
			default: cmd = CMD_JOY_5;
		endcase
		send_frame(cmd);
		idle_cycles(SETTLE);
		check_no_reply();
		check_state();
	endtask

	task automatic analog_frame();
		int          sel;
		int          t;
		int          idx;
		logic [3:0]  stick;
		logic [3:0]  pdsp;
		logic [15:0] data;
		logic [15:0] cmd;
		sel   = rand_below(4);
		pdsp  = 4'(rand_below(16));
		stick = 4'hF;
		cmd   = CMD_ANALOG_L;
		case (sel)
			0: stick = 4'(rand_below(8));
			1: begin
				cmd   = CMD_ANALOG_R;
				t     = rand_below(9);
				stick = (t == 8) ? 4'hF : 4'(t);
			end
			2: pdsp = 4'(rand_below(8));
			default: pdsp = 4'(8 + rand_below(8));
		endcase
		data = rand16();
		words.delete();
		words.push_back({8'(rand16()), pdsp, stick});
		words.push_back(data);
		if (rand_below(3) == 0)
			words.push_back(rand16());
		// only word 2 writes and out of range indices are ignored
		if (stick < NUM_PLAYERS) begin
			if (cmd == CMD_ANALOG_L)
				m_analog_l[stick] = data;
			else
				m_analog_r[stick] = data;
		end else if (cmd == CMD_ANALOG_L && stick == 4'hF) begin
			if (pdsp < NUM_PLAYERS) begin
				m_paddle[pdsp] = data[7:0];
			end else if (pdsp >= 8 && pdsp < 8 + NUM_PLAYERS) begin
				idx            = pdsp - 8;
				m_spinner[idx] = {~m_spinner[idx][8], data[7:0]};
			end
		end
		send_frame(cmd);
		idle_cycles(SETTLE);
		check_no_reply();
		check_state();
	endtask

	task automatic status_frame();
		int n;
		n = 1 + rand_below(6);
		words.delete();
		for (int i = 0; i < n; i++)
			words.push_back(rand16());
		for (int i = 0; i < n && i < 4; i++)
			m_status[16 * i +: 16] = words[i];
		send_frame(CMD_STATUS);
		idle_cycles(SETTLE);
		check_no_reply();
		check_state();
	endtask

	task automatic status_set_round();
		int          n;
		logic [63:0] req;
		logic [15:0] exp;
		n = 1 + rand_below(5);
		for (int i = 0; i < n; i++) begin
			req        = {rand16(), rand16(), rand16(), rand16()};
			status_in  = req;
			status_set = 1'b1;
			idle_cycles(1);
			status_set = 1'b0;
			status_in  = {rand16(), rand16(), rand16(), rand16()};
			idle_cycles(1 + rand_below(2));
			m_status_req = req;
			m_set_cnt    = m_set_cnt + 4'd1;
		end
		idle_cycles(SETTLE);
		words.delete();
		for (int i = 0; i < 5; i++)
			words.push_back(rand16());
		send_frame(CMD_STATUS_SET);
		// tag and counter, four request quarters, then nothing
		for (int i = 0; i < 6; i++) begin
			if (i == 0)
				exp = {STATUS_SET_TAG, 8'h00, m_set_cnt};
			else if (i <= 4)
				exp = m_status_req[16 * (i - 1) +: 16];
			else
				exp = 16'h0000;
			if (replies[i] !== exp)
				report_mismatch($sformatf("io_dout word %0d", i), replies[i], exp);
		end
		idle_cycles(SETTLE);
		check_state();
	endtask

	task automatic push_byte(input logic [7:0] b);
		words.push_back({8'(rand_below(255)), b});
	endtask

	// one of the sequences that carry a fixed code
	task automatic pick_special_key(output logic [31:0] seq, output logic [9:0] code);
		case (rand_below(3))
			0: begin
				seq  = KEY_PRNSCR_DN;
				code = KEY_PRNSCR_DN_CODE;
			end
			1: begin
				seq  = KEY_PRNSCR_UP;
				code = KEY_PRNSCR_UP_CODE;
			end
			default: begin
				seq  = KEY_PAUSE_DN;
				code = KEY_PAUSE_DN_CODE;
			end
		endcase
	endtask

	task automatic keyboard_frame();
		int          sel;
		logic [7:0]  code;
		logic [31:0] seq;
		logic [9:0]  exp_code;
		logic        skip;
		logic        old_toggle;
		sel      = rand_below(6);
		code     = 8'(rand16());
		skip     = 1'b0;
		exp_code = '0;
		words.delete();
		// expected code is pressed, extended and the last byte
		case (sel)
			0: begin
				push_byte(code);
				exp_code = {1'b1, 1'b0, code};
			end
			1: begin
				push_byte(8'hF0);
				push_byte(code);
				exp_code = {1'b0, 1'b0, code};
			end
			2: begin
				push_byte(8'hE0);
				push_byte(code);
				exp_code = {1'b1, 1'b1, code};
			end
			3: begin
				push_byte(8'hE0);
				push_byte(8'hF0);
				push_byte(code);
				exp_code = {1'b0, 1'b1, code};
			end
			4: begin
				pick_special_key(seq, exp_code);
				for (int i = 3; i >= 0; i--)
					push_byte(seq[8 * i +: 8]);
			end
			default: begin
				// FF high byte drops the whole frame
				push_byte(code);
				words.push_back({8'hFF, 8'(rand16())});
				push_byte(8'(rand16()));
				skip = 1'b1;
			end
		endcase
		old_toggle = m_ps2_key[10];
		if (!skip)
			m_ps2_key = {~m_ps2_key[10], exp_code};
		send_frame(CMD_KBD);
		if (skip)
			idle_cycles(SETTLE + 1);
		else
			wait_key_toggle(old_toggle);
		check_no_reply();
		check_state();
	endtask

	initial begin
		rng_state  = 32'd28953;
		mismatches = 0;
		timeouts   = 0;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			m_buttons[p]  = '0;
			m_analog_l[p] = '0;
			m_analog_r[p] = '0;
			m_paddle[p]   = '0;
			m_spinner[p]  = '0;
		end
		m_status     = '0;
		m_status_req = '0;
		m_set_cnt    = '0;
		m_ps2_key    = '0;

		wait_reset_release();
		idle_cycles(1);
		check_state();
		if (io_dout !== 16'h0000)
			report_mismatch("io_dout", io_dout, 64'h0);

		repeat (30) button_frame();
		repeat (60) analog_frame();
		repeat (10) status_frame();
		repeat (6) status_set_round();
		repeat (40) keyboard_frame();

		$display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hps_input_hub.f */
src/hps_input_pkg.sv
src/hps_cmd_decoder.sv
src/player_slot.sv
src/ps2_key_decoder.sv
src/status_regs.sv
src/hps_input_hub.sv
sim/tb_clock_gen.sv
sim/hps_input_hub_tb.sv
